/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bfs_accel
RTL_TOP   ?= bfs_accel
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= *** FAILED ***
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF -- "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF -- "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bfs_accel.sv */
`timescale 1ns/1ps

module bfs_accel #(
  parameter int QUEUE_DEPTH = 16,
  parameter int MEM_LINES   = 64
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         csr_valid,
  input  logic [3:0]                   csr_addr,
  input  logic                         csr_wen,
  input  logic [31:0]                  csr_wdata,
  output logic                         csr_rvalid,
  output logic                         csr_error,
  output logic [31:0]                  csr_rdata,
  input  logic                         load_en,
  input  logic [$clog2(MEM_LINES)-1:0] load_line,
  input  logic [bfs_pkg::BEAT_W-1:0]   load_beat,
  input  logic [63:0]                  load_data
);

  logic        start;
  logic [31:0] root;
  logic [31:0] target;
  logic        active;
  logic        found;
  logic        overflow;
  logic [31:0] result;

  logic        mem_req;
  logic [31:0] mem_addr;
  logic        mem_ready;
  logic        mem_valid;
  logic [63:0] mem_rdata;

  logic        q_empty;
  logic        q_full_err;
  logic        q_clear;
  logic        deq;
  logic [31:0] deq_data;
  logic [1:0]  enq_cnt;
  logic [63:0] enq_data;

  bfs_csr u_bfs_csr (
    .clk        (clk),
    .rst        (rst),
    .csr_valid  (csr_valid),
    .csr_addr   (csr_addr),
    .csr_wen    (csr_wen),
    .csr_wdata  (csr_wdata),
    .csr_rvalid (csr_rvalid),
    .csr_error  (csr_error),
    .csr_rdata  (csr_rdata),
    .start      (start),
    .root       (root),
    .target     (target),
    .active     (active),
    .found      (found),
    .overflow   (overflow),
    .result     (result)
  );

  bfs_core u_bfs_core (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .root       (root),
    .target     (target),
    .active     (active),
    .found      (found),
    .overflow   (overflow),
    .result     (result),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready),
    .mem_valid  (mem_valid),
    .mem_rdata  (mem_rdata),
    .q_empty    (q_empty),
    .q_full_err (q_full_err),
    .q_clear    (q_clear),
    .deq        (deq),
    .deq_data   (deq_data),
    .enq_cnt    (enq_cnt),
    .enq_data   (enq_data)
  );

  bfs_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_bfs_queue (
    .clk        (clk),
    .rst        (rst),
    .clear      (q_clear),
    .enq_cnt    (enq_cnt),
    .enq_data   (enq_data),
    .deq        (deq),
    .deq_data   (deq_data),
    .empty      (q_empty),
    .q_full_err (q_full_err)
  );

  graph_mem #(
    .MEM_LINES (MEM_LINES)
  ) u_graph_mem (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_line (load_line),
    .load_beat (load_beat),
    .load_data (load_data),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ready (mem_ready),
    .mem_valid (mem_valid),
    .mem_rdata (mem_rdata)
  );

endmodule

/* bfs_core.sv */
`timescale 1ns/1ps

module bfs_core (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic [31:0] root,
  input  logic [31:0] target,
  output logic        active,
  output logic        found,
  output logic        overflow,
  output logic [31:0] result,
  output logic        mem_req,
  output logic [31:0] mem_addr,
  input  logic        mem_ready,
  input  logic        mem_valid,
  input  logic [63:0] mem_rdata,
  input  logic        q_empty,
  input  logic        q_full_err,
  output logic        q_clear,
  output logic        deq,
  input  logic [31:0] deq_data,
  output logic [1:0]  enq_cnt,
  output logic [63:0] enq_data
);

  localparam int NEIGH_W = bfs_pkg::HDR_NEIGH_W;

  bfs_pkg::bfs_state_e state;

  logic [bfs_pkg::BEAT_W-1:0] beat;
  logic                       line_busy;
  logic [31:0]                cur_addr;
  logic [NEIGH_W-1:0]         neigh_left;

  logic [31:0]        hdr_value;
  logic [NEIGH_W-1:0] hdr_neighs;
  logic [NEIGH_W-1:0] hdr_neighs_clamped;
  logic               hdr_marked;
  logic               hdr_beat;
  logic               last_beat;
  logic               fresh;
  logic               hit;

  assign hdr_value  = mem_rdata[31:0];
  assign hdr_neighs = mem_rdata[bfs_pkg::HDR_NEIGH_LSB +: NEIGH_W];
  assign hdr_marked = mem_rdata[bfs_pkg::HDR_MARK_BIT];

  // A line never holds more neighbours than beats 1 to 7 can carry
  assign hdr_neighs_clamped = (hdr_neighs > NEIGH_W'(bfs_pkg::MAX_NEIGHS)) ?
                              NEIGH_W'(bfs_pkg::MAX_NEIGHS) : hdr_neighs;

  assign hdr_beat  = mem_valid & (beat == '0);
  assign last_beat = mem_valid & (beat == bfs_pkg::BEAT_W'(bfs_pkg::LINE_BEATS - 1));

  // Only a node seen for the first time counts
  assign fresh = hdr_beat & ~hdr_marked & (state == bfs_pkg::ST_NODE_HEADER);
  assign hit   = fresh & (hdr_value == target);

  assign active   = (state != bfs_pkg::ST_IDLE);
  assign q_clear  = (state == bfs_pkg::ST_INIT);
  assign mem_req  = (state == bfs_pkg::ST_NODE_HEADER) & ~line_busy & ~q_empty;
  assign mem_addr = deq_data;
  assign deq      = mem_req & mem_ready;

  always_comb begin
    enq_cnt  = 2'd0;
    enq_data = mem_rdata;
    if (state == bfs_pkg::ST_INIT) begin
      enq_cnt  = 2'd1;
      enq_data = {32'd0, root};
    end else if ((state == bfs_pkg::ST_ADD_NEIGHS) && mem_valid) begin
      // Odd last entry sits in the low half
      enq_cnt = (neigh_left > NEIGH_W'(1)) ? 2'd2 : 2'd1;
    end
  end

  // Beats are tracked even after the search stops early
  always_ff @(posedge clk) begin
    if (rst) begin
      beat      <= '0;
      line_busy <= 1'b0;
    end else begin
      if (mem_valid) begin
        beat <= beat + 1'b1;
      end
      if (deq) begin
        line_busy <= 1'b1;
      end else if (last_beat) begin
        line_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (deq) begin
      cur_addr <= deq_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= bfs_pkg::ST_IDLE;
      found      <= 1'b0;
      overflow   <= 1'b0;
      result     <= '0;
      neigh_left <= '0;
    end else begin
      case (state)
        bfs_pkg::ST_IDLE: begin
          if (start) begin
            state <= bfs_pkg::ST_INIT;
          end
        end
        bfs_pkg::ST_INIT: begin
          found    <= 1'b0;
          overflow <= 1'b0;
          state    <= bfs_pkg::ST_NODE_HEADER;
        end
        bfs_pkg::ST_NODE_HEADER: begin
          if (hit) begin
            found  <= 1'b1;
            result <= cur_addr;
            state  <= bfs_pkg::ST_IDLE;
          end else if (fresh && (hdr_neighs != '0)) begin
            neigh_left <= hdr_neighs_clamped;
            state      <= bfs_pkg::ST_ADD_NEIGHS;
          end else if (!line_busy && q_empty) begin
            // Nothing left to visit
            state <= bfs_pkg::ST_IDLE;
          end
        end
        bfs_pkg::ST_ADD_NEIGHS: begin
          if (q_full_err) begin
            overflow <= 1'b1;
            state    <= bfs_pkg::ST_IDLE;
          end else if (mem_valid) begin
            neigh_left <= neigh_left - NEIGH_W'(enq_cnt);
            if ((neigh_left <= NEIGH_W'(2)) || last_beat) begin
              state <= bfs_pkg::ST_NODE_HEADER;
            end
          end
        end
        default: state <= bfs_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

/* bfs_csr.sv */
`timescale 1ns/1ps

module bfs_csr (
  input  logic        clk,
  input  logic        rst,
  input  logic        csr_valid,
  input  logic [3:0]  csr_addr,
  input  logic        csr_wen,
  input  logic [31:0] csr_wdata,
  output logic        csr_rvalid,
  output logic        csr_error,
  output logic [31:0] csr_rdata,
  output logic        start,
  output logic [31:0] root,
  output logic [31:0] target,
  input  logic        active,
  input  logic        found,
  input  logic        overflow,
  input  logic [31:0] result
);

  logic        wr;
  logic        rd_known;
  logic [31:0] rd_word;
  logic [31:0] status;

  assign wr = csr_valid & csr_wen;

  // Writing the status register kicks off a search
  assign start = wr & (csr_addr == bfs_pkg::CSR_STAT);

  always_comb begin
    status = '0;
    status[bfs_pkg::STAT_FOUND]    = found;
    status[bfs_pkg::STAT_IDLE]     = ~active;
    status[bfs_pkg::STAT_OVERFLOW] = overflow;
  end

  always_comb begin
    rd_known = 1'b1;
    rd_word  = '0;
    case (csr_addr)
      bfs_pkg::CSR_STAT:   rd_word = status;
      bfs_pkg::CSR_ROOT:   rd_word = root;
      bfs_pkg::CSR_TARG:   rd_word = target;
      bfs_pkg::CSR_RESULT: rd_word = result;
      default:             rd_known = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      case (csr_addr)
        bfs_pkg::CSR_ROOT: root <= csr_wdata;
        bfs_pkg::CSR_TARG: target <= csr_wdata;
        default: ;
      endcase
    end
  end

  // Response one cycle after the access
  always_ff @(posedge clk) begin
    if (rst) begin
      csr_rvalid <= 1'b0;
      csr_error  <= 1'b0;
    end else begin
      csr_rvalid <= csr_valid;
      csr_error  <= csr_valid & ~rd_known;
    end
  end

  always_ff @(posedge clk) begin
    if (csr_valid) begin
      csr_rdata <= rd_word;
    end
  end

endmodule

/* bfs_pkg.sv */
package bfs_pkg;

  // Node line layout, eight 64-bit beats per 64-byte line
  localparam int LINE_BEATS = 8;
  localparam int BEAT_W     = 3;

  // Header beat 0 fields
  localparam int HDR_NEIGH_LSB = 32;
  localparam int HDR_NEIGH_W   = 4;
  localparam int HDR_MARK_BIT  = 56;

  // Two node addresses per beat in beats 1 to 7
  localparam int MAX_NEIGHS = 14;

  typedef enum logic [3:0] {
    CSR_STAT   = 4'd0,
    CSR_ROOT   = 4'd1,
    CSR_TARG   = 4'd2,
    CSR_RESULT = 4'd5
  } csr_addr_e;

  // Status word bits
  localparam int STAT_FOUND    = 0;
  localparam int STAT_IDLE     = 1;
  localparam int STAT_OVERFLOW = 2;

  typedef enum logic [1:0] {
    ST_IDLE        = 2'd0,
    ST_INIT        = 2'd1,
    ST_NODE_HEADER = 2'd2,
    ST_ADD_NEIGHS  = 2'd3
  } bfs_state_e;

endpackage

/* bfs_properties.sv */
`timescale 1ns/1ps

module bfs_properties (
  input logic                clk,
  input logic                rst,
  input bfs_pkg::bfs_state_e state,
  input logic                mem_req,
  input logic                mem_valid,
  input logic                q_full_err,
  input logic                found,
  input logic                overflow,
  input logic                active,
  input logic                hit
);

  // No new request while beats return
  no_req_in_line: assert property (@(posedge clk) disable iff (rst)
    mem_valid |-> !mem_req)
    else $error("mem_req high while a line is returning");

  // Root enqueue always fits after the clear
  ovf_from_neighs: assert property (@(posedge clk) disable iff (rst)
    q_full_err |-> (state == bfs_pkg::ST_ADD_NEIGHS))
    else $error("queue overflow outside ST_ADD_NEIGHS");

  found_xor_ovf: assert property (@(posedge clk) disable iff (rst)
    !(found && overflow))
    else $error("found and overflow both set");

  // Hit ends the search on the same edge
  hit_stops: assert property (@(posedge clk) disable iff (rst)
    hit |=> !active)
    else $error("core still active after a hit");

endmodule

bind bfs_core bfs_properties u_bfs_properties (
  .clk        (clk),
  .rst        (rst),
  .state      (state),
  .mem_req    (mem_req),
  .mem_valid  (mem_valid),
  .q_full_err (q_full_err),
  .found      (found),
  .overflow   (overflow),
  .active     (active),
  .hit        (hit)
);

/* bfs_queue.sv */
`timescale 1ns/1ps

module bfs_queue #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear,
  input  logic [1:0]  enq_cnt,
  input  logic [63:0] enq_data,
  input  logic        deq,
  output logic [31:0] deq_data,
  output logic        empty,
  output logic        q_full_err
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [31:0] entries [QUEUE_DEPTH];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] head_b;
  logic [PTR_W-1:0] tail_b;
  logic [PTR_W-1:0] tail_n;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_b;
  logic [CNT_W-1:0] free;
  logic [CNT_W-1:0] enq_n;
  logic             do_enq;
  logic             do_deq;

  // Clear and the root enqueue land in the same cycle
  assign head_b  = clear ? '0 : head;
  assign tail_b  = clear ? '0 : tail;
  assign count_b = clear ? '0 : count;
  assign tail_n  = tail_b + 1'b1;

  assign free       = CNT_W'(QUEUE_DEPTH) - count_b;
  assign enq_n      = CNT_W'(enq_cnt);
  assign q_full_err = (enq_n > free);

  // Entries that do not fit are dropped
  assign do_enq = (enq_cnt != 2'd0) & ~q_full_err;
  assign do_deq = deq & (count_b != '0);

  assign deq_data = entries[head];
  assign empty    = (count == '0);

  always_ff @(posedge clk) begin
    if (do_enq) begin
      entries[tail_b] <= enq_data[31:0];
      if (enq_cnt == 2'd2) begin
        entries[tail_n] <= enq_data[63:32];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= do_deq ? head_b + 1'b1 : head_b;
      tail  <= do_enq ? tail_b + PTR_W'(enq_cnt) : tail_b;
      count <= count_b + (do_enq ? enq_n : '0) - CNT_W'(do_deq);
    end
  end

endmodule

/* filelist.f */
bfs_pkg.sv
bfs_csr.sv
bfs_core.sv
bfs_queue.sv
graph_mem.sv
bfs_accel.sv
bfs_properties.sv
tb_bfs_accel.sv

/* graph_mem.sv */
`timescale 1ns/1ps

module graph_mem #(
  parameter int MEM_LINES = 64
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         load_en,
  input  logic [$clog2(MEM_LINES)-1:0] load_line,
  input  logic [bfs_pkg::BEAT_W-1:0]   load_beat,
  input  logic [63:0]                  load_data,
  input  logic                         mem_req,
  input  logic [31:0]                  mem_addr,
  output logic                         mem_ready,
  output logic                         mem_valid,
  output logic [63:0]                  mem_rdata
);

  localparam int LINE_W   = $clog2(MEM_LINES);
  localparam int LINE_OFS = $clog2(bfs_pkg::LINE_BEATS * 8);
  localparam int IDX_W    = LINE_W + bfs_pkg::BEAT_W;

  logic [63:0] lines [MEM_LINES * bfs_pkg::LINE_BEATS];

  logic                       busy;
  logic                       launch;
  logic                       accept;
  logic [LINE_W-1:0]          rd_line;
  logic [bfs_pkg::BEAT_W-1:0] rd_beat;
  logic [IDX_W-1:0]           rd_idx;
  logic [IDX_W-1:0]           ld_idx;

  // One line in flight, ready returns the cycle after the last beat
  assign mem_ready = ~busy;
  assign accept    = mem_req & mem_ready;
  assign rd_idx    = {rd_line, rd_beat};
  assign ld_idx    = {load_line, load_beat};

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      launch    <= 1'b0;
      rd_beat   <= '0;
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= launch;
      if (accept) begin
        busy    <= 1'b1;
        launch  <= 1'b1;
        rd_beat <= '0;
      end else if (launch) begin
        rd_beat <= rd_beat + 1'b1;
        if (rd_beat == bfs_pkg::BEAT_W'(bfs_pkg::LINE_BEATS - 1)) begin
          launch <= 1'b0;
        end
      end else if (mem_valid) begin
        // Last beat on the bus
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rd_line <= mem_addr[LINE_OFS +: LINE_W];
    end
  end

  // Header goes out with the old mark, the array keeps the new one
  always_ff @(posedge clk) begin
    if (launch) begin
      mem_rdata <= lines[rd_idx];
    end
    if (load_en) begin
      lines[ld_idx] <= load_data;
    end else if (launch && (rd_beat == '0)) begin
      lines[rd_idx][bfs_pkg::HDR_MARK_BIT] <= 1'b1;
    end
  end

endmodule

/* tb_bfs_accel.sv */
`timescale 1ns/1ps

module tb_bfs_accel;

  localparam int QUEUE_DEPTH = 16;
  localparam int MEM_LINES   = 64;
  localparam int LINE_W      = $clog2(MEM_LINES);
  localparam int CLK_PERIOD  = 8;
  localparam int N_SEARCHES  = 7;
  // Each queued entry costs at most one line read
  localparam int SEARCH_CYCLES = (MEM_LINES * bfs_pkg::MAX_NEIGHS + 1) * 16;
  localparam int LOAD_CYCLES   = MEM_LINES * bfs_pkg::LINE_BEATS + 16;

  logic                       clk;
  logic                       rst;
  logic                       csr_valid;
  logic [3:0]                 csr_addr;
  logic                       csr_wen;
  logic [31:0]                csr_wdata;
  logic                       csr_rvalid;
  logic                       csr_error;
  logic [31:0]                csr_rdata;
  logic                       load_en;
  logic [LINE_W-1:0]          load_line;
  logic [bfs_pkg::BEAT_W-1:0] load_beat;
  logic [63:0]                load_data;

  // Graph copy shared by the loader and the reference model
  logic [31:0] node_val [MEM_LINES];
  int          node_cnt [MEM_LINES];
  int          node_nb  [MEM_LINES][bfs_pkg::MAX_NEIGHS];

  logic [15:0] lfsr_state;
  int          errors;
  int          checks;

  bfs_accel #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .MEM_LINES   (MEM_LINES)
  ) u_bfs_accel (
    .clk        (clk),
    .rst        (rst),
    .csr_valid  (csr_valid),
    .csr_addr   (csr_addr),
    .csr_wen    (csr_wen),
    .csr_wdata  (csr_wdata),
    .csr_rvalid (csr_rvalid),
    .csr_error  (csr_error),
    .csr_rdata  (csr_rdata),
    .load_en    (load_en),
    .load_line  (load_line),
    .load_beat  (load_beat),
    .load_data  (load_data)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] line_addr(input int l);
    return 32'(l) << 6;
  endfunction

  task automatic expect_eq(input string test, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", test, what, exp, act);
    end
  endtask

  task automatic csr_access(input string test, input logic [3:0] addr, input logic wen,
                            input logic [31:0] data, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk);
    expect_eq(test, "rvalid before access", 32'd0, 32'(csr_rvalid));
    csr_valid = 1'b1;
    csr_addr  = addr;
    csr_wen   = wen;
    csr_wdata = data;
    @(negedge clk);
    csr_valid = 1'b0;
    csr_wen   = 1'b0;
    expect_eq(test, "rvalid after access", 32'd1, 32'(csr_rvalid));
    rdata = csr_rdata;
    err   = csr_error;
  endtask

  task automatic csr_write(input string test, input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused_rdata;
    logic        err;
    csr_access(test, addr, 1'b1, data, unused_rdata, err);
    expect_eq(test, "write error", 32'd0, 32'(err));
  endtask

  task automatic csr_read(input string test, input logic [3:0] addr,
                          output logic [31:0] data, output logic err);
    csr_access(test, addr, 1'b0, 32'd0, data, err);
  endtask

  task automatic clear_graph();
    for (int i = 0; i < MEM_LINES; i++) begin
      node_val[i] = 32'h1000 + 32'(i);
      node_cnt[i] = 0;
      for (int k = 0; k < bfs_pkg::MAX_NEIGHS; k++) begin
        node_nb[i][k] = 0;
      end
    end
  endtask

  // Node i has children 2i+1 and 2i+2 below n
  task automatic build_tree(input int n);
    clear_graph();
    for (int i = 0; i < n; i++) begin
      if (2 * i + 1 < n) begin
        node_nb[i][node_cnt[i]] = 2 * i + 1;
        node_cnt[i]++;
      end
      if (2 * i + 2 < n) begin
        node_nb[i][node_cnt[i]] = 2 * i + 2;
        node_cnt[i]++;
      end
    end
  endtask

  task automatic load_graph();
    logic [63:0] beat_data;
    for (int l = 0; l < MEM_LINES; l++) begin
      for (int b = 0; b < bfs_pkg::LINE_BEATS; b++) begin
        beat_data = '0;
        if (b == 0) begin
          beat_data[31:0] = node_val[l];
          beat_data[bfs_pkg::HDR_NEIGH_LSB +: 4] = 4'(node_cnt[l]);
        end else begin
          if (2 * b - 2 < node_cnt[l]) begin
            beat_data[31:0] = line_addr(node_nb[l][2 * b - 2]);
          end
          if (2 * b - 1 < node_cnt[l]) begin
            beat_data[63:32] = line_addr(node_nb[l][2 * b - 1]);
          end
        end
        @(negedge clk);
        load_en   = 1'b1;
        load_line = LINE_W'(l);
        load_beat = bfs_pkg::BEAT_W'(b);
        load_data = beat_data;
      end
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  // FIFO order, a node is expanded on its first visit only
  task automatic ref_bfs(input int root_line, input logic [31:0] targ, output logic e_found,
                         output logic e_ovf, output logic [31:0] e_result);
    int q[$];
    bit seen [MEM_LINES];
    int node;
    int k;
    int n;
    e_found  = 1'b0;
    e_ovf    = 1'b0;
    e_result = '0;
    for (int i = 0; i < MEM_LINES; i++) begin
      seen[i] = 1'b0;
    end
    q.push_back(root_line);
    while (q.size() > 0 && !e_found && !e_ovf) begin
      node = q.pop_front();
      if (!seen[node]) begin
        seen[node] = 1'b1;
        if (node_val[node] == targ) begin
          e_found  = 1'b1;
          e_result = line_addr(node);
        end else begin
          k = 0;
          while (k < node_cnt[node] && !e_ovf) begin
            n = (node_cnt[node] - k >= 2) ? 2 : 1;
            if (q.size() + n > QUEUE_DEPTH) begin
              e_ovf = 1'b1;
            end else begin
              q.push_back(node_nb[node][k]);
              if (n == 2) begin
                q.push_back(node_nb[node][k + 1]);
              end
              k += n;
            end
          end
        end
      end
    end
  endtask

  task automatic run_search(input string test, input int root_line, input logic [31:0] targ,
                            output logic got_found, output logic got_ovf);
    logic [31:0] stat;
    logic [31:0] res;
    logic        err;
    logic        e_found;
    logic        e_ovf;
    logic [31:0] e_result;
    ref_bfs(root_line, targ, e_found, e_ovf, e_result);
    csr_write(test, bfs_pkg::CSR_ROOT, line_addr(root_line));
    csr_write(test, bfs_pkg::CSR_TARG, targ);
    csr_write(test, bfs_pkg::CSR_STAT, 32'd0);
    stat = '0;
    while (stat[bfs_pkg::STAT_IDLE] !== 1'b1) begin
      csr_read(test, bfs_pkg::CSR_STAT, stat, err);
    end
    got_found = stat[bfs_pkg::STAT_FOUND];
    got_ovf   = stat[bfs_pkg::STAT_OVERFLOW];
    expect_eq(test, "found", 32'(e_found), 32'(got_found));
    expect_eq(test, "overflow", 32'(e_ovf), 32'(got_ovf));
    if (e_found) begin
      csr_read(test, bfs_pkg::CSR_RESULT, res, err);
      expect_eq(test, "result", e_result, res);
    end
  endtask

  task automatic test_csr_regs();
    logic [31:0] data;
    logic        err;
    csr_write("csr_regs", bfs_pkg::CSR_ROOT, 32'h1234_5680);
    csr_write("csr_regs", bfs_pkg::CSR_TARG, 32'hCAFE_F00D);
    csr_read("csr_regs", bfs_pkg::CSR_ROOT, data, err);
    expect_eq("csr_regs", "root", 32'h1234_5680, data);
    expect_eq("csr_regs", "root error", 32'd0, 32'(err));
    csr_read("csr_regs", bfs_pkg::CSR_TARG, data, err);
    expect_eq("csr_regs", "target", 32'hCAFE_F00D, data);
    csr_read("csr_regs", 4'd7, data, err);
    expect_eq("csr_regs", "unknown address error", 32'd1, 32'(err));
    csr_read("csr_regs", bfs_pkg::CSR_STAT, data, err);
    expect_eq("csr_regs", "idle after reset", 32'd1, 32'(data[bfs_pkg::STAT_IDLE]));
  endtask

  task automatic test_tree_hit(input string test);
    logic f;
    logic o;
    build_tree(63);
    // Same value on two levels, the shallower node wins
    node_val[11] = 32'd77;
    node_val[25] = 32'd77;
    load_graph();
    run_search(test, 0, 32'd77, f, o);
    expect_eq(test, "target reached", 32'd1, 32'(f));
  endtask

  task automatic test_unreachable(input string test);
    logic f;
    logic o;
    build_tree(15);
    load_graph();
    run_search(test, 0, 32'hDEAD_BEEF, f, o);
    expect_eq(test, "not found", 32'd0, 32'(f));
    expect_eq(test, "no overflow", 32'd0, 32'(o));
  endtask

  task automatic test_cycles();
    logic f;
    logic o;
    clear_graph();
    // Ring of eight with a skip edge and a shared edge back to node 0
    for (int i = 0; i < 8; i++) begin
      node_cnt[i]   = 3;
      node_nb[i][0] = (i + 1) % 8;
      node_nb[i][1] = (i + 2) % 8;
      node_nb[i][2] = 0;
    end
    load_graph();
    run_search("cycles_hit", 0, node_val[7], f, o);
    load_graph();
    run_search("cycles_miss", 0, 32'hDEAD_BEEF, f, o);
    expect_eq("cycles_miss", "not found", 32'd0, 32'(f));
  endtask

  task automatic test_overflow();
    logic f;
    logic o;
    clear_graph();
    for (int i = 0; i < MEM_LINES; i++) begin
      node_val[i] = rand_bits(16);
      node_cnt[i] = 10 + int'(rand_bits(2));
      for (int k = 0; k < node_cnt[i]; k++) begin
        node_nb[i][k] = int'(rand_bits(LINE_W));
      end
    end
    load_graph();
    run_search("overflow", 0, 32'hFFFF_FFFF, f, o);
    expect_eq("overflow", "overflow set", 32'd1, 32'(o));
  endtask

  initial begin
    lfsr_state = 16'd15;
    errors     = 0;
    checks     = 0;
    rst        = 1'b1;
    csr_valid  = 1'b0;
    csr_addr   = '0;
    csr_wen    = 1'b0;
    csr_wdata  = '0;
    load_en    = 1'b0;
    load_line  = '0;
    load_beat  = '0;
    load_data  = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_csr_regs();
    test_tree_hit("tree_hit");
    test_unreachable("unreachable");
    test_cycles();
    test_overflow();
    // Restart after overflow, then after a hit
    test_tree_hit("restart_hit");
    test_unreachable("restart_miss");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (N_SEARCHES * (SEARCH_CYCLES + LOAD_CYCLES) + 1000) @(posedge clk);
    $display("Timeout: the searches did not finish in the expected time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule
